// File: csr_testdata.txt
// op addr data pc cause exp_data exp_epc exp_status; op 0 read 1 write 2 trap 3 mret 4 sret
// 5 irq 6 wait ff end; status [1:0] mode [4] m_eie [5] m_tie [6] s_eie [7] s_tie [8] m_timer
0  301 00000000 00000000 00000000 40141100 00000000 003
0  300 00000000 00000000 00000000 00001800 00000000 003
1  305 00000103 00000000 00000000 00000000 00000000 000
0  305 00000000 00000000 00000000 00000100 00000100 003
1  141 0000abcf 00000000 00000000 00000000 00000000 000
0  141 00000000 00000000 00000000 0000abcc 00000100 003
1  302 ffffffff 00000000 00000000 00000000 00000000 000
0  302 00000000 00000000 00000000 0000ffff 00000100 003
1  303 ffffffff 00000000 00000000 00000000 00000000 000
0  303 00000000 00000000 00000000 00000fff 00000100 003
1  340 deadbeef 00000000 00000000 00000000 00000000 000
1  300 00001808 00000000 00000000 00000000 00000000 000
1  304 00000aa0 00000000 00000000 00000000 00000000 000
0  304 00000000 00000000 00000000 00000aa0 00000100 033
// illegal instruction in M, mscratch write in the same cycle
2  340 0badc0de 00001006 00000002 00000000 00000100 003
0  340 00000000 00000000 00000000 deadbeef 00000100 003
0  341 00000000 00000000 00000000 00001004 00000100 003
0  342 00000000 00000000 00000000 00000002 00000100 003
0  343 00000000 00000000 00000000 0badc0df 00000100 003
0  300 00000000 00000000 00000000 00001880 00000100 003
3  000 00000000 00000000 00000000 00000000 00001004 033
2  000 00000000 00002002 00000000 00000000 00000100 003
0  341 00000000 00000000 00000000 00002000 00000100 003
0  343 00000000 00000000 00000000 00002002 00000100 003
3  000 00000000 00000000 00000000 00000000 00002000 033
3  000 00000000 00000000 00000000 00000000 00002000 030
// ecall from U, delegated to S
2  000 00000000 00003008 00000008 00000000 00000100 031
0  141 00000000 00000000 00000000 00003008 00000100 031
0  142 00000000 00000000 00000000 00000008 00000100 031
0  143 00000000 00000000 00000000 00000000 00000100 031
0  300 00000000 00000000 00000000 00000088 00000100 031
4  000 00000000 00000000 00000000 00000000 00003008 030
1  300 0000000a 00000000 00000000 00000000 00000000 000
0  300 00000000 00000000 00000000 0000000a 00000100 0f0
1  302 00000100 00000000 00000000 00000000 00000000 000
2  000 00000073 00004000 00000002 00000000 00000100 0c3
0  343 00000000 00000000 00000000 00000073 00000100 0c3
0  300 00000000 00000000 00000000 00000082 00000100 0c3
2  000 00000000 00005004 00000008 00000000 00000100 0c3
0  341 00000000 00000000 00000000 00005004 00000100 0c3
0  300 00000000 00000000 00000000 00001802 00000100 0c3
5  000 00000003 00000000 00000000 00000000 00000000 000
0  344 00000000 00000000 00000000 00000a00 00000100 0c3
5  000 00000000 00000000 00000000 00000000 00000000 000
2  000 12345678 00006001 8000000b 00000000 00000100 0c3
0  343 00000000 00000000 00000000 00000000 00000100 0c3
0  342 00000000 00000000 00000000 8000000b 00000100 0c3
6  000 00000004 00000000 00000000 00000000 00000000 000
0  7c1 00000000 00000000 00000000 ffffffff 00000100 0c3
3  000 00000000 00000000 00000000 00000000 00006000 0c3
ff 000 00000000 00000000 00000000 00000000 00000000 000

// File: list.f
csr_pkg.sv
priv_pkg.sv
csr_mode_fsm.sv
csr_timer.sv
csr_status_regs.sv
csr_trap_regs.sv
csr_unit.sv
tb_csr_unit.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - priv_pkg.sv
  - csr_mode_fsm.sv
  - csr_timer.sv
  - csr_status_regs.sv
  - csr_trap_regs.sv
  - csr_unit.sv
  - target: test
    files:
      - tb_csr_unit.sv

// File: tb_csr_unit.sv
module tb_csr_unit;
	timeunit 1ns;
	timeprecision 100ps;

	import csr_pkg::*;
	import priv_pkg::*;

	localparam int max_lines     = 64;
	localparam int words_per_line = 8;
	localparam int random_rounds = 4;
	localparam int timer_gap     = 7;  // cycles between the two mcycle reads
	localparam int timer_lead    = 16; // mtimecmp distance ahead of mcycle

	// opcodes of the data file
	localparam logic [31:0] op_read  = 32'h0;
	localparam logic [31:0] op_write = 32'h1;
	localparam logic [31:0] op_trap  = 32'h2;
	localparam logic [31:0] op_mret  = 32'h3;
	localparam logic [31:0] op_sret  = 32'h4;
	localparam logic [31:0] op_irq   = 32'h5;
	localparam logic [31:0] op_wait  = 32'h6;
	localparam logic [31:0] op_end   = 32'hff;

	logic clk, nrst;
	csr_addr_t csr_address_r, csr_address_wb;
	logic csr_we;
	logic [xlen-1:0] csr_wb;
	logic trap, mret, sret;
	logic [xlen-1:0] cause, pc_exc;
	logic [29:0] instruction_word;
	logic m_interrupt, s_interrupt;
	logic [xlen-1:0] csr_data, epc;
	mode_t current_mode;
	logic m_timer, m_eie, m_tie, s_eie, s_tie;

	logic [31:0] test_mem [0:words_per_line*max_lines-1];
	int line_count;
	int cycle_limit = 0;
	int cycle_count = 0;

	csr_unit #(.counter_width(64)) dut (
		.clk(clk), .nrst(nrst),
		.csr_address_r(csr_address_r), .csr_address_wb(csr_address_wb),
		.csr_we(csr_we), .csr_wb(csr_wb),
		.trap(trap), .mret(mret), .sret(sret),
		.cause(cause), .pc_exc(pc_exc), .instruction_word(instruction_word),
		.m_interrupt(m_interrupt), .s_interrupt(s_interrupt),
		.csr_data(csr_data), .epc(epc), .current_mode(current_mode),
		.m_timer(m_timer), .m_eie(m_eie), .m_tie(m_tie), .s_eie(s_eie), .s_tie(s_tie)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// watchdog and failure exit
	//////////////////////////////////////////////////
	task automatic stop_run();
		$display("tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			stop_run();
		end
	end

	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// status word bits [1:0] mode [4] m_eie [5] m_tie [6] s_eie [7] s_tie [8] m_timer
	task automatic check_status(input string what, input logic [31:0] exp);
		logic [31:0] got;
		got = {23'b0, m_timer, s_tie, s_eie, m_tie, m_eie, 2'b00, current_mode};
		check_word(what, got, exp);
	endtask

	//////////////////////////////////////////////////
	// cycle level drivers
	//////////////////////////////////////////////////
	task automatic drive_idle();
		csr_we           = 1'b0;
		csr_address_wb   = '0;
		csr_wb           = '0;
		trap             = 1'b0;
		mret             = 1'b0;
		sret             = 1'b0;
		cause            = '0;
		pc_exc           = '0;
		instruction_word = '0;
	endtask

	task automatic next_cycle(); // inputs change 1 ns after the edge
		@(posedge clk);
		#1;
		drive_idle();
	endtask

	task automatic drive_write(input csr_addr_t addr, input logic [31:0] data);
		csr_we         = 1'b1;
		csr_address_wb = addr;
		csr_wb         = data;
	endtask

	task automatic read_csr(input csr_addr_t addr, output logic [31:0] value);
		next_cycle();
		csr_address_r = addr;
		#2;
		value = csr_data;
	endtask

	// checks epc during the pulse and the status one cycle later
	task automatic check_event(input int i, input logic [31:0] exp_epc,
			input logic [31:0] exp_status);
		#2;
		check_word($sformatf("line %0d epc", i), epc, exp_epc);
		next_cycle();
		#2;
		check_status($sformatf("line %0d status", i), exp_status);
	endtask

	task automatic count_lines();
		logic found;
		found = 1'b0;
		line_count = 0;
		while (!found && (line_count < max_lines)
				&& !$isunknown(test_mem[words_per_line*line_count]))
		begin
			if (test_mem[words_per_line*line_count] == op_end)
				found = 1'b1;
			else
				line_count++;
		end
		if (!found)
		begin
			$display("the test data file is missing or has no end marker");
			stop_run();
		end
	endtask

	task automatic run_line(input int i);
		logic [31:0] op, data, pc, cause_word, exp_data, exp_epc, exp_status;
		csr_addr_t addr;
		op         = test_mem[words_per_line*i];
		addr       = test_mem[words_per_line*i+1][11:0];
		data       = test_mem[words_per_line*i+2];
		pc         = test_mem[words_per_line*i+3];
		cause_word = test_mem[words_per_line*i+4];
		exp_data   = test_mem[words_per_line*i+5];
		exp_epc    = test_mem[words_per_line*i+6];
		exp_status = test_mem[words_per_line*i+7];
		case (op)
			op_read:
			begin
				next_cycle();
				csr_address_r = addr;
				#2;
				check_word($sformatf("line %0d csr_data", i), csr_data, exp_data);
				check_word($sformatf("line %0d epc", i), epc, exp_epc);
				check_status($sformatf("line %0d status", i), exp_status);
			end
			op_write:
			begin
				next_cycle();
				drive_write(addr, data);
			end
			op_trap:
			begin
				next_cycle();
				trap             = 1'b1;
				cause            = cause_word;
				pc_exc           = pc;
				instruction_word = data[31:2];
				if (addr != '0)
					drive_write(addr, data); // collides with the trap
				check_event(i, exp_epc, exp_status);
			end
			op_mret:
			begin
				next_cycle();
				mret = 1'b1;
				check_event(i, exp_epc, exp_status);
			end
			op_sret:
			begin
				next_cycle();
				sret = 1'b1;
				check_event(i, exp_epc, exp_status);
			end
			op_irq:
			begin
				next_cycle();
				m_interrupt = data[0];
				s_interrupt = data[1];
			end
			op_wait: repeat (data) next_cycle();
			default:
			begin
				$display("unknown opcode %0h on test data line %0d", op, i);
				stop_run();
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// generated checks
	//////////////////////////////////////////////////
	// ecall from M with a random pc and mret back to M
	task automatic random_trap_round();
		logic [31:0] pc, value, aligned;
		pc      = $urandom;
		aligned = {pc[31:2], 2'b00};
		next_cycle();
		trap   = 1'b1;
		cause  = 32'(ecall_m);
		pc_exc = pc;
		read_csr(addr_mepc, value);
		check_word("random trap mepc", value, aligned);
		read_csr(addr_mcause, value);
		check_word("random trap mcause", value, 32'(ecall_m));
		read_csr(addr_mtval, value);
		check_word("random trap mtval", value, '0);
		next_cycle();
		mret = 1'b1;
		#2;
		check_word("random trap epc on mret", epc, aligned);
		next_cycle();
		#2;
		check_word("random trap mode", 32'(current_mode), 32'(mode_m));
	endtask

	// each enable output needs its own mie bit as well as its level enable
	task automatic enable_test();
		logic [31:0] value;
		next_cycle();
		drive_write(addr_mstatus, 32'h0000_180a); // sie and mie with mpp at M
		next_cycle();
		drive_write(addr_mie, 32'h0000_0280); // mti and sei only
		read_csr(addr_mie, value);
		check_word("mie with mti and sei", value, 32'h0000_0280);
		check_status("enables with mti and sei", 32'h0000_0063);
		next_cycle();
		drive_write(addr_mie, 32'h0000_0820); // mei and sti only
		read_csr(addr_mie, value);
		check_word("mie with mei and sti", value, 32'h0000_0820);
		check_status("enables with mei and sti", 32'h0000_0093);
		next_cycle();
		m_interrupt = 1'b1;
		read_csr(addr_mip, value);
		check_word("mip with m_interrupt", value, 32'h0000_0800);
		next_cycle();
		m_interrupt = 1'b0;
		s_interrupt = 1'b1;
		read_csr(addr_mip, value);
		check_word("mip with s_interrupt", value, 32'h0000_0200);
		next_cycle();
		s_interrupt = 1'b0;
	endtask

	task automatic timer_test();
		logic [31:0] first, second, value;
		read_csr(addr_mcycle, first);
		repeat (timer_gap - 1) next_cycle();
		read_csr(addr_mcycle, second);
		check_word("mcycle difference", second - first, timer_gap);
		next_cycle();
		drive_write(addr_mtimecmph, '0);
		next_cycle();
		drive_write(addr_mtimecmp, second + 2 + timer_lead); // mcycle of this cycle plus lead
		for (int n = 1; n <= timer_lead + 4; n++)
		begin
			next_cycle();
			#2;
			check_word($sformatf("m_timer %0d cycles after the write", n),
				{31'b0, m_timer}, {31'b0, n > timer_lead});
		end
		read_csr(addr_mip, value);
		check_word("mip with m_timer", value, 32'h0000_0080);
	endtask

	initial
	begin
		void'($urandom(15749));
		nrst          = 1'b0;
		csr_address_r = '0;
		m_interrupt   = 1'b0;
		s_interrupt   = 1'b0;
		drive_idle();
		$readmemh("csr_testdata.txt", test_mem);
		count_lines();
		cycle_limit = 4 * line_count + 200;
		repeat (3) @(posedge clk);
		#1;
		nrst = 1'b1;
		for (int i = 0; i < line_count; i++)
			run_line(i);
		repeat (random_rounds) random_trap_round();
		enable_test();
		timer_test();
		$display("all tests passed");
		$finish;
	end

endmodule

// File: csr_unit.sv
module csr_unit #(
	parameter int unsigned counter_width = 64
) (
	input logic clk,
	input logic nrst,
	input csr_pkg::csr_addr_t csr_address_r,
	input csr_pkg::csr_addr_t csr_address_wb,
	input logic csr_we,
	input logic [csr_pkg::xlen-1:0] csr_wb,
	input logic trap,
	input logic mret,
	input logic sret,
	input logic [csr_pkg::xlen-1:0] cause,
	input logic [csr_pkg::xlen-1:0] pc_exc,
	input logic [29:0] instruction_word,
	input logic m_interrupt,
	input logic s_interrupt,
	output logic [csr_pkg::xlen-1:0] csr_data,
	output logic [csr_pkg::xlen-1:0] epc,
	output priv_pkg::mode_t current_mode,
	output logic m_timer,
	output logic m_eie,
	output logic m_tie,
	output logic s_eie,
	output logic s_tie
);
	import csr_pkg::*;
	import priv_pkg::*;

	logic wb_en; // write strobe after trap priority
	logic to_s, spp;
	mode_t mpp;
	logic [xlen-1:0] mstatus, mie, mip, medeleg, mideleg;
	logic [xlen-1:0] mtvec, mscratch, mepc, mcause, mtval, sepc, scause, stval;
	logic [counter_width-1:0] mcycle, mtimecmp;

	// trap, mret and sret all win over a pending write
	assign wb_en = csr_we && !(trap || mret || sret);

	csr_mode_fsm u_mode_fsm (
		.clk(clk), .nrst(nrst),
		.trap(trap), .mret(mret), .sret(sret),
		.cause(cause), .medeleg(medeleg), .mideleg(mideleg),
		.mpp(mpp), .spp(spp),
		.current_mode(current_mode), .next_mode(), .to_s(to_s)
	);

	csr_timer #(.counter_width(counter_width)) u_timer (
		.clk(clk), .nrst(nrst),
		.csr_we(wb_en), .csr_address_wb(csr_address_wb), .csr_wb(csr_wb),
		.mcycle(mcycle), .mtimecmp(mtimecmp), .m_timer(m_timer)
	);

	csr_status_regs u_status_regs (
		.clk(clk), .nrst(nrst),
		.csr_we(wb_en), .csr_address_wb(csr_address_wb), .csr_wb(csr_wb),
		.trap(trap), .mret(mret), .sret(sret), .to_s(to_s),
		.current_mode(current_mode),
		.m_timer(m_timer), .m_interrupt(m_interrupt), .s_interrupt(s_interrupt),
		.mstatus(mstatus), .mie(mie), .mip(mip), .medeleg(medeleg), .mideleg(mideleg),
		.mpp(mpp), .spp(spp),
		.m_eie(m_eie), .m_tie(m_tie), .s_eie(s_eie), .s_tie(s_tie)
	);

	csr_trap_regs u_trap_regs (
		.clk(clk), .nrst(nrst),
		.csr_we(wb_en), .csr_address_wb(csr_address_wb), .csr_wb(csr_wb),
		.trap(trap), .to_s(to_s),
		.cause(cause), .pc_exc(pc_exc), .instruction_word(instruction_word),
		.mtvec(mtvec), .mscratch(mscratch), .mepc(mepc), .mcause(mcause),
		.mtval(mtval), .sepc(sepc), .scause(scause), .stval(stval)
	);

	//////////////////////////////////////////////////
	// read multiplexer
	//////////////////////////////////////////////////
	always_comb
	begin
		case (csr_address_r)
			addr_misa:      csr_data = misa_value;
			addr_mvendorid,
			addr_marchid,
			addr_mimpid,
			addr_mhartid:   csr_data = '0;
			addr_mstatus:   csr_data = mstatus;
			addr_mie:       csr_data = mie;
			addr_mip:       csr_data = mip;
			addr_medeleg:   csr_data = medeleg;
			addr_mideleg:   csr_data = mideleg;
			addr_mtvec:     csr_data = mtvec;
			addr_mscratch:  csr_data = mscratch;
			addr_mepc:      csr_data = mepc;
			addr_mcause:    csr_data = mcause;
			addr_mtval:     csr_data = mtval;
			addr_sepc:      csr_data = sepc;
			addr_scause:    csr_data = scause;
			addr_stval:     csr_data = stval;
			addr_mcycle:    csr_data = mcycle[xlen-1:0];
			addr_mcycleh:   csr_data = xlen'(mcycle >> xlen); // zero extended upper half
			addr_mtimecmp:  csr_data = mtimecmp[xlen-1:0];
			addr_mtimecmph: csr_data = xlen'(mtimecmp >> xlen);
			default:        csr_data = '0;
		endcase
	end

	// mret and sret return through mepc and sepc and traps use mtvec (no stvec)
	always_comb
	begin
		if (mret)
			epc = mepc;
		else if (sret)
			epc = sepc;
		else
			epc = mtvec;
	end

endmodule

// File: csr_trap_regs.sv
module csr_trap_regs (
	input logic clk,
	input logic nrst,
	input logic csr_we,
	input csr_pkg::csr_addr_t csr_address_wb,
	input logic [csr_pkg::xlen-1:0] csr_wb,
	input logic trap,
	input logic to_s,
	input logic [csr_pkg::xlen-1:0] cause,
	input logic [csr_pkg::xlen-1:0] pc_exc,
	input logic [29:0] instruction_word,
	output logic [csr_pkg::xlen-1:0] mtvec,
	output logic [csr_pkg::xlen-1:0] mscratch,
	output logic [csr_pkg::xlen-1:0] mepc,
	output logic [csr_pkg::xlen-1:0] mcause,
	output logic [csr_pkg::xlen-1:0] mtval,
	output logic [csr_pkg::xlen-1:0] sepc,
	output logic [csr_pkg::xlen-1:0] scause,
	output logic [csr_pkg::xlen-1:0] stval
);
	import csr_pkg::*;
	import priv_pkg::*;

	// word aligned registers, low two bits are not stored
	logic [xlen-1:2] mtvec_base;
	logic [xlen-1:2] mepc_word;
	logic [xlen-1:2] sepc_word;

	logic [xlen-1:0] tval_value;
	logic m_capture, s_capture;

	assign m_capture = trap && !to_s;
	assign s_capture = trap && to_s;

	//////////////////////////////////////////////////
	// trap value
	//////////////////////////////////////////////////
	always_comb
	begin
		tval_value = '0;
		if (!cause[xlen-1]) // interrupts leave tval zero
		begin
			case (cause[4:0])
				i_addr_misaligned: tval_value = pc_exc;
				i_illegal:         tval_value = {instruction_word, 2'b11};
				default:           tval_value = '0;
			endcase
		end
	end

	// trap vector, direct mode only
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			mtvec_base <= '0;
		else if (!trap && csr_we && (csr_address_wb == addr_mtvec))
			mtvec_base <= csr_wb[xlen-1:2];
	end

	//////////////////////////////////////////////////
	// trap capture and software writes
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (m_capture)
		begin
			mepc_word <= pc_exc[xlen-1:2];
			mcause    <= cause;
			mtval     <= tval_value;
		end
		else if (s_capture)
		begin
			sepc_word <= pc_exc[xlen-1:2];
			scause    <= cause;
			stval     <= tval_value;
		end
		else if (csr_we)
		begin
			case (csr_address_wb)
				addr_mscratch: mscratch  <= csr_wb;
				addr_mepc:     mepc_word <= csr_wb[xlen-1:2];
				addr_mcause:   mcause    <= csr_wb;
				addr_mtval:    mtval     <= csr_wb;
				addr_sepc:     sepc_word <= csr_wb[xlen-1:2];
				addr_scause:   scause    <= csr_wb;
				addr_stval:    stval     <= csr_wb;
				default: ;
			endcase
		end
	end

	assign mtvec = {mtvec_base, 2'b00};
	assign mepc  = {mepc_word, 2'b00};
	assign sepc  = {sepc_word, 2'b00};

endmodule

// File: csr_status_regs.sv
module csr_status_regs (
	input logic clk,
	input logic nrst,
	input logic csr_we,
	input csr_pkg::csr_addr_t csr_address_wb,
	input logic [csr_pkg::xlen-1:0] csr_wb,
	input logic trap,
	input logic mret,
	input logic sret,
	input logic to_s,
	input priv_pkg::mode_t current_mode,
	input logic m_timer,
	input logic m_interrupt,
	input logic s_interrupt,
	output logic [csr_pkg::xlen-1:0] mstatus,
	output logic [csr_pkg::xlen-1:0] mie,
	output logic [csr_pkg::xlen-1:0] mip,
	output logic [csr_pkg::xlen-1:0] medeleg,
	output logic [csr_pkg::xlen-1:0] mideleg,
	output priv_pkg::mode_t mpp,
	output logic spp,
	output logic m_eie,
	output logic m_tie,
	output logic s_eie,
	output logic s_tie
);
	import csr_pkg::*;
	import priv_pkg::*;

	logic status_sie, status_mie, status_spie, status_mpie, status_sum;
	logic en_stie, en_mtie, en_seie, en_meie; // mie register bits

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			status_sie  <= 1'b0;
			status_mie  <= 1'b0;
			status_spie <= 1'b0;
			status_mpie <= 1'b0;
			status_sum  <= 1'b0;
			spp         <= 1'b0;
			mpp         <= mode_m;
			en_stie     <= 1'b0;
			en_mtie     <= 1'b0;
			en_seie     <= 1'b0;
			en_meie     <= 1'b0;
			medeleg     <= '0;
			mideleg     <= '0;
		end
		else if (trap && to_s)
		begin
			status_spie <= status_sie; // stack into supervisor level
			status_sie  <= 1'b0;
			spp         <= current_mode[0];
		end
		else if (trap)
		begin
			status_mpie <= status_mie;
			status_mie  <= 1'b0;
			mpp         <= current_mode;
		end
		else if (mret)
		begin
			status_mie  <= status_mpie;
			status_mpie <= 1'b1;
			mpp         <= mode_u;
		end
		else if (sret)
		begin
			status_sie  <= status_spie;
			status_spie <= 1'b1;
			spp         <= 1'b0;
		end
		else if (csr_we)
		begin
			case (csr_address_wb)
				addr_mstatus:
				begin
					status_sie  <= csr_wb[1];
					status_mie  <= csr_wb[3];
					status_spie <= csr_wb[5];
					status_mpie <= csr_wb[7];
					spp         <= csr_wb[8];
					status_sum  <= csr_wb[18];
					if (csr_wb[12:11] != 2'b10) // reserved encoding keeps old mpp
						mpp <= mode_t'(csr_wb[12:11]);
				end
				addr_mie:
				begin
					en_stie <= csr_wb[sti];
					en_mtie <= csr_wb[mti];
					en_seie <= csr_wb[sei];
					en_meie <= csr_wb[mei];
				end
				addr_medeleg: medeleg <= csr_wb & medeleg_mask;
				addr_mideleg: mideleg <= csr_wb & mideleg_mask;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// register views
	//////////////////////////////////////////////////
	always_comb
	begin
		mstatus        = '0;
		mstatus[1]     = status_sie;
		mstatus[3]     = status_mie;
		mstatus[5]     = status_spie;
		mstatus[7]     = status_mpie;
		mstatus[8]     = spp;
		mstatus[12:11] = mpp;
		mstatus[18]    = status_sum;

		mie      = '0;
		mie[sti] = en_stie;
		mie[mti] = en_mtie;
		mie[sei] = en_seie;
		mie[mei] = en_meie;

		// no supervisor timer source, sti stays clear
		mip      = '0;
		mip[mti] = m_timer;
		mip[sei] = s_interrupt;
		mip[mei] = m_interrupt;
	end

	// enable seen by the core: local bit and global level enable
	assign m_eie = en_meie && status_mie;
	assign m_tie = en_mtie && status_mie;
	assign s_eie = en_seie && status_sie;
	assign s_tie = en_stie && status_sie;

endmodule

// File: csr_timer.sv
module csr_timer #(
	parameter int unsigned counter_width = 64
) (
	input logic clk,
	input logic nrst,
	input logic csr_we,
	input csr_pkg::csr_addr_t csr_address_wb,
	input logic [csr_pkg::xlen-1:0] csr_wb,
	output logic [counter_width-1:0] mcycle,
	output logic [counter_width-1:0] mtimecmp,
	output logic m_timer
);
	import csr_pkg::*;

	// width of the upper half seen through the h registers
	localparam int unsigned high_width = counter_width - xlen;

	//////////////////////////////////////////////////
	// free running cycle counter
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mcycle <= '0;
		end
		else
		begin
			mcycle <= mcycle + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// compare register, written one half at a time
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mtimecmp <= '1; // far future, no interrupt
		end
		else if (csr_we)
		begin
			if (csr_address_wb == addr_mtimecmp)
				mtimecmp[xlen-1:0] <= csr_wb;
			else if (csr_address_wb == addr_mtimecmph)
				mtimecmp[counter_width-1:xlen] <= csr_wb[high_width-1:0];
		end
	end

	// level stays up while the counter is past the compare value
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			m_timer <= 1'b0;
		else
			m_timer <= (mcycle >= mtimecmp);
	end

endmodule

// File: csr_mode_fsm.sv
module csr_mode_fsm (
	input logic clk,
	input logic nrst,
	input logic trap,
	input logic mret,
	input logic sret,
	input logic [csr_pkg::xlen-1:0] cause,
	input logic [csr_pkg::xlen-1:0] medeleg,
	input logic [csr_pkg::xlen-1:0] mideleg,
	input priv_pkg::mode_t mpp,
	input logic spp,
	output priv_pkg::mode_t current_mode,
	output priv_pkg::mode_t next_mode,
	output logic to_s
);
	import csr_pkg::*;
	import priv_pkg::*;

	logic [4:0] code;
	logic is_interrupt;
	logic delegated;

	assign code         = cause[4:0];
	assign is_interrupt = cause[xlen-1];

	// interrupts look in mideleg, exceptions in medeleg
	assign delegated = is_interrupt ? mideleg[code] : medeleg[code];

	//////////////////////////////////////////////////
	// next mode
	//////////////////////////////////////////////////
	always_comb
	begin
		next_mode = current_mode;
		if (trap)
		begin
			// a trap never goes below the current level
			if (delegated && (current_mode != mode_m))
				next_mode = mode_s;
			else
				next_mode = mode_m;
		end
		else if (mret)
		begin
			next_mode = mpp;
		end
		else if (sret)
		begin
			next_mode = spp ? mode_s : mode_u;
		end
	end

	// trap handled by the supervisor level
	assign to_s = trap && (next_mode == mode_s);

	//////////////////////////////////////////////////
	// mode register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= mode_m; // start in machine mode
		end
		else
		begin
			current_mode <= next_mode;
		end
	end

endmodule

// File: priv_pkg.sv
package priv_pkg;

	// privilege levels, value 2 is reserved
	typedef enum logic [1:0] {
		mode_u = 2'b00,
		mode_s = 2'b01,
		mode_m = 2'b11
	} mode_t;

	//////////////////////////////////////////////////
	// exception codes (interrupt flag clear)
	//////////////////////////////////////////////////
	localparam logic [4:0] i_addr_misaligned = 5'd0;
	localparam logic [4:0] i_illegal         = 5'd2;
	localparam logic [4:0] ecall_u           = 5'd8;
	localparam logic [4:0] ecall_s           = 5'd9;
	localparam logic [4:0] ecall_m           = 5'd11;

	//////////////////////////////////////////////////
	// interrupt codes, also the mip / mie bit positions
	//////////////////////////////////////////////////
	localparam logic [4:0] ssi = 5'd1;  // supervisor software
	localparam logic [4:0] msi = 5'd3;  // machine software
	localparam logic [4:0] sti = 5'd5;  // supervisor timer
	localparam logic [4:0] mti = 5'd7;  // machine timer
	localparam logic [4:0] sei = 5'd9;  // supervisor external
	localparam logic [4:0] mei = 5'd11; // machine external

endpackage

// File: csr_pkg.sv
package csr_pkg;

	//////////////////////////////////////////////////
	// data width and address type
	//////////////////////////////////////////////////
	localparam int unsigned xlen = 32;

	typedef logic [11:0] csr_addr_t;

	//////////////////////////////////////////////////
	// csr addresses
	//////////////////////////////////////////////////
	// machine identity, all read zero
	localparam csr_addr_t addr_mvendorid = 12'hF11;
	localparam csr_addr_t addr_marchid   = 12'hF12;
	localparam csr_addr_t addr_mimpid    = 12'hF13;
	localparam csr_addr_t addr_mhartid   = 12'hF14;

	// machine trap setup and handling
	localparam csr_addr_t addr_mstatus  = 12'h300;
	localparam csr_addr_t addr_misa     = 12'h301;
	localparam csr_addr_t addr_medeleg  = 12'h302;
	localparam csr_addr_t addr_mideleg  = 12'h303;
	localparam csr_addr_t addr_mie      = 12'h304;
	localparam csr_addr_t addr_mtvec    = 12'h305;
	localparam csr_addr_t addr_mscratch = 12'h340;
	localparam csr_addr_t addr_mepc     = 12'h341;
	localparam csr_addr_t addr_mcause   = 12'h342;
	localparam csr_addr_t addr_mtval    = 12'h343;
	localparam csr_addr_t addr_mip      = 12'h344;

	// supervisor trap handling
	localparam csr_addr_t addr_sepc   = 12'h141;
	localparam csr_addr_t addr_scause = 12'h142;
	localparam csr_addr_t addr_stval  = 12'h143;

	// counters, mtimecmp sits in the custom read/write range
	localparam csr_addr_t addr_mcycle    = 12'hB00;
	localparam csr_addr_t addr_mcycleh   = 12'hB80;
	localparam csr_addr_t addr_mtimecmp  = 12'h7C0;
	localparam csr_addr_t addr_mtimecmph = 12'h7C1;

	// MXL=1 (rv32), extensions I, M, S and U
	localparam logic [xlen-1:0] misa_value = 32'h4014_1100;

	// writable delegation bits
	localparam logic [xlen-1:0] medeleg_mask = 32'h0000_FFFF;
	localparam logic [xlen-1:0] mideleg_mask = 32'h0000_0FFF;

endpackage
